//--- include/img_ctrl_consts.svh
`ifndef IMG_CTRL_CONSTS_SVH
`define IMG_CTRL_CONSTS_SVH

// ========================================
// Image geometry
// ========================================
`define IMG_WIDTH 16
`define IMG_HEIGHT 8
`define IMG_PIXELS (`IMG_WIDTH * `IMG_HEIGHT)
`define PIXEL_ADDR_BITS 7

// Wide enough to count past the store depth
`define PIXEL_COUNT_BITS 10

// ========================================
// Readout stream layout
// ========================================
`define HEADER_WORDS 4
`define PADDING_WORDS 2

// Capture statistics and frame skipping
`define STAT_BITS 8
`define SKIP_BITS 2

`endif

//--- src/pixel_pkg.sv
`include "img_ctrl_consts.svh"

package pixel_pkg;

    // Raw sensor sample
    typedef logic [11:0] pixel_t;

    // Little-endian layout of a 12-bit pixel in a 16-bit word
    typedef struct packed {
        logic [7:0] lo_byte;
        logic [3:0] pad;
        logic [3:0] hi_nibble;
    } pixel_fields_t;

    // Capture builds the word from fields, readout sees a plain word
    typedef union packed {
        logic [15:0]   raw;
        pixel_fields_t fields;
    } pixel_word_u;

    // Highlight and shadow counters
    typedef logic [`STAT_BITS-1:0] stat_count_t;

endpackage

//--- src/readout_pkg.sv
package readout_pkg;

    // Readout sequencer steps
    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        PIXELS,
        CHECKSUM_WAIT,
        TRAILER
    } readout_state_e;

    // Fletcher-32 result with sum B in [31:16] and sum A in [15:0]
    typedef logic [31:0] checksum_t;

endpackage

//--- src/frame_bus_if.sv
interface frame_bus_if;

    // Write side
    logic                   wr_clear;
    logic                   wr_en;
    pixel_pkg::pixel_word_u wr_data;

    // Read side
    logic                   rd_clear;
    logic                   rd_en;
    pixel_pkg::pixel_word_u rd_data;

    modport writer (
        output wr_clear, wr_en, wr_data
    );

    modport store (
        input  wr_clear, wr_en, wr_data, rd_clear, rd_en,
        output rd_data
    );

    modport reader (
        output rd_clear, rd_en,
        input  rd_data
    );

endinterface

//--- src/pixel_capture.sv
`include "img_ctrl_consts.svh"

module pixel_capture (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         cmd_capture,
    input  logic [`SKIP_BITS-1:0]        cmd_skip_count,
    input  pixel_pkg::pixel_t            img_d,
    input  logic                         img_fv,
    input  logic                         img_lv,
    output logic                         capture_done,
    output logic [`PIXEL_COUNT_BITS-1:0] pixel_count,
    output pixel_pkg::stat_count_t       highlight_count,
    output pixel_pkg::stat_count_t       shadow_count,
    frame_bus_if.writer                  bus
);

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_ARM,
        CAP_WAIT_FRAME,
        CAP_GRAB
    } cap_state_e;

    cap_state_e             state;
    pixel_pkg::pixel_t      d_q;
    pixel_pkg::pixel_t      stat_px;
    pixel_pkg::pixel_word_u word;
    logic                   fv_q;
    logic                   lv_q;
    logic                   fv_prev;
    logic                   lv_prev;
    logic                   frame_start;
    logic                   line_end;
    logic                   grab_now;
    logic                   take;
    logic                   wr_en;
    logic                   stat_chk;
    logic [1:0]             x;
    logic [1:0]             y;
    logic [`SKIP_BITS-1:0]  skip_cnt;

    assign frame_start = fv_q && !fv_prev;
    assign line_end    = lv_prev && !lv_q;

    // The first sample of the kept frame may coincide with its frame start
    assign grab_now = (state == CAP_GRAB) ||
                      (state == CAP_WAIT_FRAME && frame_start && skip_cnt == '0);
    assign take     = grab_now && lv_q;

    assign bus.wr_clear = (state == CAP_ARM);
    assign bus.wr_en    = wr_en;

    // Pack pixel bits 7:0 into the upper byte
    always_comb begin
        word.fields.lo_byte   = d_q[7:0];
        word.fields.pad       = 4'h0;
        word.fields.hi_nibble = d_q[11:8];
    end

    // ========================================
    // Data path
    // ========================================
    always_ff @(posedge clk) begin
        d_q         <= img_d;
        stat_px     <= d_q;
        bus.wr_data <= word;
    end

    // ========================================
    // Control and statistics
    // ========================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fv_q            <= 1'b0;
            lv_q            <= 1'b0;
            fv_prev         <= 1'b0;
            lv_prev         <= 1'b0;
            x               <= '0;
            y               <= '0;
            state           <= CAP_IDLE;
            skip_cnt        <= '0;
            wr_en           <= 1'b0;
            stat_chk        <= 1'b0;
            capture_done    <= 1'b0;
            pixel_count     <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            fv_q         <= img_fv;
            lv_q         <= img_lv;
            fv_prev      <= fv_q;
            lv_prev      <= lv_q;
            capture_done <= 1'b0;
            wr_en        <= take;
            stat_chk     <= take && x == 2'd0 && y == 2'd0;

            // Grid position wraps every 4 in both directions
            if (!lv_q) begin
                x <= '0;
            end else begin
                x <= x + 1'b1;
            end
            if (!fv_q) begin
                y <= '0;
            end else if (line_end) begin
                y <= y + 1'b1;
            end

            if (wr_en) begin
                pixel_count <= pixel_count + 1'b1;
            end

            // Top 7 bits decide highlight or shadow
            if (stat_chk) begin
                if (&stat_px[11:5]) begin
                    highlight_count <= highlight_count + 1'b1;
                end else if (~|stat_px[11:5]) begin
                    shadow_count <= shadow_count + 1'b1;
                end
            end

            case (state)
                CAP_ARM: begin
                    pixel_count     <= '0;
                    highlight_count <= '0;
                    shadow_count    <= '0;
                    skip_cnt        <= cmd_skip_count;
                    state           <= CAP_WAIT_FRAME;
                end
                CAP_WAIT_FRAME: begin
                    if (frame_start) begin
                        if (skip_cnt == '0) begin
                            state <= CAP_GRAB;
                        end else begin
                            skip_cnt <= skip_cnt - 1'b1;
                        end
                    end
                end
                CAP_GRAB: begin
                    if (!fv_q) begin
                        capture_done <= 1'b1;
                        state        <= CAP_IDLE;
                    end
                end
                default: begin
                end
            endcase

            // A new command always restarts the grabber
            if (cmd_capture) begin
                state <= CAP_ARM;
            end
        end
    end

endmodule

//--- src/frame_store.sv
`include "img_ctrl_consts.svh"

module frame_store (
    input logic         clk,
    input logic         arst_n,
    frame_bus_if.store  bus
);

    pixel_pkg::pixel_word_u mem [`IMG_PIXELS];

    // Extra bit so a full store is visible
    logic [`PIXEL_ADDR_BITS:0]   wr_addr;
    logic [`PIXEL_ADDR_BITS-1:0] rd_addr;
    logic                        wr_ok;

    assign wr_ok = bus.wr_en && !bus.wr_clear && (wr_addr < `IMG_PIXELS);

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_addr[`PIXEL_ADDR_BITS-1:0]] <= bus.wr_data;
        end
    end

    // Address counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_addr <= '0;
            rd_addr <= '0;
        end else begin
            if (bus.wr_clear) begin
                wr_addr <= '0;
            end else if (wr_ok) begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (bus.rd_clear) begin
                rd_addr <= '0;
            end else if (bus.rd_en) begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // Word at the current read address
    assign bus.rd_data = mem[rd_addr];

endmodule

//--- src/fletcher_checksum.sv
module fletcher_checksum (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   clear,
    input  logic                   en,
    input  logic [15:0]            din,
    output readout_pkg::checksum_t dout
);

    logic [15:0] sum_a;
    logic [15:0] sum_b;
    logic [15:0] next_a;

    // Addition modulo 65535
    function automatic logic [15:0] add_mod(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= 17'd65535) begin
            s = s - 17'd65535;
        end
        return s[15:0];
    endfunction

    assign next_a = add_mod(sum_a, din);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (en) begin
            sum_a <= next_a;
            sum_b <= add_mod(sum_b, next_a);
        end
    end

    assign dout = {sum_b, sum_a};

endmodule

//--- src/readout_ctrl.sv
`include "img_ctrl_consts.svh"

module readout_ctrl (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        cmd_readout,
    input  logic [`HEADER_WORDS*16-1:0] cmd_header,
    input  logic                        readout_trigger,
    output logic                        readout_start,
    output logic                        readout_ready,
    output logic [15:0]                 readout_data,
    output logic                        readout_done,
    frame_bus_if.reader                 bus
);

    localparam int HDR_BITS      = `HEADER_WORDS * 16;
    localparam int TRAILER_WORDS = 2 + `PADDING_WORDS;
    localparam int TRL_BITS      = TRAILER_WORDS * 16;

    readout_pkg::readout_state_e state;
    readout_pkg::checksum_t      ck_sum;
    logic                        start_pend;
    logic                        load;
    logic                        ck_en;
    logic [15:0]                 ck_din;
    logic [HDR_BITS-1:0]         hdr_shift;
    logic [TRL_BITS-1:0]         trl_shift;
    logic [`PIXEL_ADDR_BITS-1:0] cnt;
    logic [1:0]                  wait_cnt;

    // Output register is empty or drains this cycle
    assign load = !readout_ready || readout_trigger;

    assign bus.rd_clear = start_pend;
    assign bus.rd_en    = (state == readout_pkg::PIXELS) && load;

    // Host treats stream words as little endian
    function automatic logic [15:0] byte_swap(input logic [15:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    fletcher_checksum u_checksum (
        .clk    (clk),
        .arst_n (arst_n),
        .clear  (start_pend),
        .en     (ck_en),
        .din    (ck_din),
        .dout   (ck_sum)
    );

    // ========================================
    // Sequencer
    // ========================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= readout_pkg::IDLE;
            start_pend    <= 1'b0;
            readout_start <= 1'b0;
            readout_ready <= 1'b0;
            readout_data  <= '0;
            readout_done  <= 1'b0;
            ck_en         <= 1'b0;
            ck_din        <= '0;
            hdr_shift     <= '0;
            trl_shift     <= '0;
            cnt           <= '0;
            wait_cnt      <= '0;
        end else begin
            start_pend    <= 1'b0;
            readout_start <= 1'b0;
            ck_en         <= 1'b0;
            if (readout_trigger) begin
                readout_ready <= 1'b0;
            end

            if (start_pend) begin
                readout_start <= 1'b1;
                readout_done  <= 1'b0;
                hdr_shift     <= cmd_header;
                cnt           <= '0;
                state         <= readout_pkg::HEADER;
            end else begin
                case (state)
                    // Most significant header word first
                    readout_pkg::HEADER: begin
                        if (load) begin
                            readout_data  <= hdr_shift[HDR_BITS-1 -: 16];
                            readout_ready <= 1'b1;
                            ck_en         <= 1'b1;
                            ck_din        <= byte_swap(hdr_shift[HDR_BITS-1 -: 16]);
                            hdr_shift     <= hdr_shift << 16;
                            cnt           <= cnt + 1'b1;
                            if (cnt == `HEADER_WORDS - 1) begin
                                cnt   <= '0;
                                state <= readout_pkg::PIXELS;
                            end
                        end
                    end
                    readout_pkg::PIXELS: begin
                        if (load) begin
                            readout_data  <= bus.rd_data.raw;
                            readout_ready <= 1'b1;
                            ck_en         <= 1'b1;
                            ck_din        <= byte_swap(bus.rd_data.raw);
                            cnt           <= cnt + 1'b1;
                            if (cnt == `IMG_PIXELS - 1) begin
                                wait_cnt <= '0;
                                state    <= readout_pkg::CHECKSUM_WAIT;
                            end
                        end
                    end
                    // Let the last word settle into the sums
                    readout_pkg::CHECKSUM_WAIT: begin
                        if (wait_cnt == 2'd2) begin
                            trl_shift <= {ck_sum[7:0], ck_sum[15:8],
                                          ck_sum[23:16], ck_sum[31:24],
                                          {(`PADDING_WORDS * 16){1'b0}}};
                            cnt       <= '0;
                            state     <= readout_pkg::TRAILER;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                    // Checksum then padding until the last word is taken
                    readout_pkg::TRAILER: begin
                        if (load) begin
                            if (cnt == TRAILER_WORDS) begin
                                readout_done <= 1'b1;
                                state        <= readout_pkg::IDLE;
                            end else begin
                                readout_data  <= trl_shift[TRL_BITS-1 -: 16];
                                readout_ready <= 1'b1;
                                trl_shift     <= trl_shift << 16;
                                cnt           <= cnt + 1'b1;
                            end
                        end
                    end
                    default: begin
                    end
                endcase
            end

            // A new command abandons any stream underway
            if (cmd_readout) begin
                state         <= readout_pkg::IDLE;
                readout_ready <= 1'b0;
                ck_en         <= 1'b0;
                start_pend    <= 1'b1;
            end
        end
    end

endmodule

//--- src/img_ctrl.sv
`include "img_ctrl_consts.svh"

module img_ctrl (
    input  logic                         clk,
    input  logic                         arst_n,

    // Commands
    input  logic                         cmd_capture,
    input  logic                         cmd_readout,
    input  logic [`SKIP_BITS-1:0]        cmd_skip_count,
    input  logic [`HEADER_WORDS*16-1:0]  cmd_header,

    // Camera bus
    input  logic [11:0]                  img_d,
    input  logic                         img_fv,
    input  logic                         img_lv,

    // Readout port
    output logic                         readout_start,
    output logic                         readout_ready,
    input  logic                         readout_trigger,
    output logic [15:0]                  readout_data,
    output logic                         readout_done,

    // Capture status
    output logic                         capture_done,
    output logic [`PIXEL_COUNT_BITS-1:0] capture_pixel_count,
    output pixel_pkg::stat_count_t       capture_highlight_count,
    output pixel_pkg::stat_count_t       capture_shadow_count
);

    frame_bus_if fbus ();

    // ========================================
    // Capture into the frame store
    // ========================================
    pixel_capture u_capture (
        .clk             (clk),
        .arst_n          (arst_n),
        .cmd_capture     (cmd_capture),
        .cmd_skip_count  (cmd_skip_count),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .capture_done    (capture_done),
        .pixel_count     (capture_pixel_count),
        .highlight_count (capture_highlight_count),
        .shadow_count    (capture_shadow_count),
        .bus             (fbus.writer)
    );

    frame_store u_store (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (fbus.store)
    );

    // ========================================
    // Readout stream
    // ========================================
    readout_ctrl u_readout (
        .clk             (clk),
        .arst_n          (arst_n),
        .cmd_readout     (cmd_readout),
        .cmd_header      (cmd_header),
        .readout_trigger (readout_trigger),
        .readout_start   (readout_start),
        .readout_ready   (readout_ready),
        .readout_data    (readout_data),
        .readout_done    (readout_done),
        .bus             (fbus.reader)
    );

endmodule

//--- testbench/img_ctrl_properties.sv
module img_ctrl_properties (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        readout_trigger,
    input logic                        readout_start,
    input logic                        readout_ready,
    input logic [15:0]                 readout_data,
    input readout_pkg::readout_state_e state
);

    // Host stall keeps the offered word in place
    stall_holds_data: assert property (
        @(posedge clk) disable iff (!arst_n)
        readout_ready && !readout_trigger |=> $stable(readout_data)
    ) else $error("readout_data changed while the host stalled");

    start_is_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        readout_start |=> !readout_start
    ) else $error("readout_start stayed high for more than one cycle");

    // Nothing is offered while the sequencer is idle
    idle_not_ready: assert property (
        @(posedge clk) disable iff (!arst_n)
        state == readout_pkg::IDLE |-> !readout_ready
    ) else $error("readout_ready high while the sequencer is idle");

endmodule

bind readout_ctrl img_ctrl_properties u_props (
    .clk             (clk),
    .arst_n          (arst_n),
    .readout_trigger (readout_trigger),
    .readout_start   (readout_start),
    .readout_ready   (readout_ready),
    .readout_data    (readout_data),
    .state           (state)
);

//--- testbench/img_ctrl_tb.sv
`include "img_ctrl_consts.svh"

module img_ctrl_tb;

    localparam int FV_LEAD         = 3;
    localparam int LINE_GAP        = 4;
    localparam int FV_TAIL         = 6;
    localparam int FRAME_CYCLES    = FV_LEAD + `IMG_HEIGHT * (`IMG_WIDTH + LINE_GAP + 2) + FV_TAIL;
    localparam int STREAM_WORDS    = `HEADER_WORDS + `IMG_PIXELS + 2 + `PADDING_WORDS;
    localparam int READOUT_LIMIT   = 4 * STREAM_WORDS + 32;
    localparam int NUM_FRAMES      = 6;
    localparam int NUM_READOUTS    = 4;
    localparam int WATCHDOG_CYCLES = 2 * (NUM_FRAMES * FRAME_CYCLES +
                                          NUM_READOUTS * READOUT_LIMIT) + 200;

    logic                         clk;
    logic                         arst_n;
    logic                         cmd_capture;
    logic                         cmd_readout;
    logic [`SKIP_BITS-1:0]        cmd_skip_count;
    logic [`HEADER_WORDS*16-1:0]  cmd_header;
    logic [11:0]                  img_d;
    logic                         img_fv;
    logic                         img_lv;
    logic                         readout_trigger;
    logic                         readout_start;
    logic                         readout_ready;
    logic [15:0]                  readout_data;
    logic                         readout_done;
    logic                         capture_done;
    logic [`PIXEL_COUNT_BITS-1:0] capture_pixel_count;
    pixel_pkg::stat_count_t       capture_highlight_count;
    pixel_pkg::stat_count_t       capture_shadow_count;

    integer            seed = 87492;
    int                errors = 0;
    int                checks = 0;
    bit                cap_done_seen;
    pixel_pkg::pixel_t frame_px [`IMG_PIXELS];
    pixel_pkg::pixel_t exp_px [`IMG_PIXELS];
    logic [15:0]       exp_q[$];
    logic [15:0]       rx_q[$];

    img_ctrl dut0 (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .cmd_capture             (cmd_capture),
        .cmd_readout             (cmd_readout),
        .cmd_skip_count          (cmd_skip_count),
        .cmd_header              (cmd_header),
        .img_d                   (img_d),
        .img_fv                  (img_fv),
        .img_lv                  (img_lv),
        .readout_start           (readout_start),
        .readout_ready           (readout_ready),
        .readout_trigger         (readout_trigger),
        .readout_data            (readout_data),
        .readout_done            (readout_done),
        .capture_done            (capture_done),
        .capture_pixel_count     (capture_pixel_count),
        .capture_highlight_count (capture_highlight_count),
        .capture_shadow_count    (capture_shadow_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error [%s]: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // Advance one clock edge and remember a capture_done pulse
    task automatic step_clock();
        @(posedge clk);
        if (capture_done) begin
            cap_done_seen = 1'b1;
        end
    endtask

    // Highlights on line 0 grid points, shadows on part of line 4
    function automatic void fill_stats_frame();
        int i;
        int x;
        int y;
        for (i = 0; i < `IMG_PIXELS; i++) begin
            x = i % `IMG_WIDTH;
            y = i / `IMG_WIDTH;
            if (x % 4 == 0 && y % 4 == 0) begin
                if (y == 0) begin
                    frame_px[i] = 12'hFE0;
                end else if (x < 8) begin
                    frame_px[i] = 12'h01F;
                end else begin
                    frame_px[i] = 12'h020;
                end
            end else if (x == 1) begin
                frame_px[i] = 12'hFFF;
            end else if (x == 2) begin
                frame_px[i] = 12'h000;
            end else begin
                frame_px[i] = i[11:0];
            end
        end
    endfunction

    // Tag in the top nibble keeps frames apart
    function automatic void fill_random_frame(input logic [3:0] tag);
        int i;
        int rnd;
        for (i = 0; i < `IMG_PIXELS; i++) begin
            rnd = $random(seed);
            frame_px[i] = {tag, rnd[7:0]};
        end
    endfunction

    // Grid points sit where x and y are both multiples of 4
    function automatic void count_grid(output int hi, output int sh);
        int i;
        hi = 0;
        sh = 0;
        for (i = 0; i < `IMG_PIXELS; i++) begin
            if ((i % `IMG_WIDTH) % 4 == 0 && (i / `IMG_WIDTH) % 4 == 0) begin
                if (exp_px[i][11:5] == 7'h7F) begin
                    hi++;
                end else if (exp_px[i][11:5] == 7'h00) begin
                    sh++;
                end
            end
        end
    endfunction

    // Expected stream from the header and the stored frame
    function automatic void build_expected(input logic [`HEADER_WORDS*16-1:0] header);
        int i;
        int a;
        int b;
        int sw;
        exp_q.delete();
        for (i = `HEADER_WORDS - 1; i >= 0; i--) begin
            exp_q.push_back(header[i*16 +: 16]);
        end
        for (i = 0; i < `IMG_PIXELS; i++) begin
            exp_q.push_back({exp_px[i][7:0], 4'h0, exp_px[i][11:8]});
        end
        a = 0;
        b = 0;
        foreach (exp_q[k]) begin
            sw = {16'd0, exp_q[k][7:0], exp_q[k][15:8]};
            a = (a + sw) % 65535;
            b = (b + a) % 65535;
        end
        // Sum A bytes first, then sum B, low byte leading
        exp_q.push_back({a[7:0], a[15:8]});
        exp_q.push_back({b[7:0], b[15:8]});
        for (i = 0; i < `PADDING_WORDS; i++) begin
            exp_q.push_back(16'h0000);
        end
    endfunction

    task automatic start_capture(input logic [`SKIP_BITS-1:0] skip);
        cap_done_seen = 1'b0;
        cmd_skip_count <= skip;
        cmd_capture    <= 1'b1;
        step_clock();
        cmd_capture <= 1'b0;
        repeat (2) step_clock();
    endtask

    // Drives frame_px and optionally re-issues the capture before one line
    task automatic send_frame(input int restart_line);
        int idx;
        int ln;
        int px;
        idx = 0;
        img_fv <= 1'b1;
        repeat (FV_LEAD) step_clock();
        for (ln = 0; ln < `IMG_HEIGHT; ln++) begin
            if (ln == restart_line) begin
                cmd_capture <= 1'b1;
                step_clock();
                cmd_capture <= 1'b0;
                step_clock();
            end
            for (px = 0; px < `IMG_WIDTH; px++) begin
                img_lv <= 1'b1;
                img_d  <= frame_px[idx];
                idx++;
                step_clock();
            end
            img_lv <= 1'b0;
            img_d  <= '0;
            repeat (LINE_GAP) step_clock();
        end
        img_fv <= 1'b0;
        repeat (FV_TAIL) step_clock();
    endtask

    task automatic wait_capture_done(input string name);
        int cycles;
        cycles = 0;
        while (!cap_done_seen && cycles < 32) begin
            step_clock();
            cycles++;
        end
        if (!cap_done_seen) begin
            errors++;
            $display("%s: capture_done never pulsed after the frame", name);
        end
    endtask

    task automatic check_counts(input string name, input int pixels);
        int hi;
        int sh;
        count_grid(hi, sh);
        check_value({name, " pixel count"}, pixels, 32'(capture_pixel_count));
        check_value({name, " highlights"}, hi, 32'(capture_highlight_count));
        check_value({name, " shadows"}, sh, 32'(capture_shadow_count));
    endtask

    // Issue a readout, collect every transferred word and compare with the model
    task automatic run_readout(input string name, input bit random_trigger);
        logic [`HEADER_WORDS*16-1:0] header;
        int                          i;
        int                          rnd;
        int                          cycles;
        bit                          start_seen;
        bit                          done_seen;
        for (i = 0; i < `HEADER_WORDS; i++) begin
            rnd = $random(seed);
            header[i*16 +: 16] = rnd[15:0];
        end
        build_expected(header);
        rx_q.delete();
        start_seen = 1'b0;
        done_seen  = 1'b0;
        cycles     = 0;
        cmd_header  <= header;
        cmd_readout <= 1'b1;
        step_clock();
        cmd_readout <= 1'b0;
        while (!done_seen && cycles < READOUT_LIMIT) begin
            step_clock();
            cycles++;
            if (readout_ready && readout_trigger) begin
                rx_q.push_back(readout_data);
            end
            if (readout_start) begin
                start_seen = 1'b1;
            end else if (start_seen && readout_done) begin
                done_seen = 1'b1;
            end
            if (random_trigger) begin
                rnd = $random(seed);
                readout_trigger <= rnd[0];
            end else begin
                readout_trigger <= 1'b1;
            end
        end
        if (!start_seen) begin
            errors++;
            $display("%s: readout_start never pulsed", name);
        end
        if (!done_seen) begin
            errors++;
            $display("%s: readout did not finish within %0d cycles", name, READOUT_LIMIT);
        end
        check_value({name, " word count"}, STREAM_WORDS, rx_q.size());
        for (i = 0; i < STREAM_WORDS && i < rx_q.size(); i++) begin
            check_value($sformatf("%s word %0d", name, i), 32'(exp_q[i]), 32'(rx_q[i]));
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic test_capture_stats();
        start_capture(2'd0);
        fill_stats_frame();
        exp_px = frame_px;
        send_frame(-1);
        wait_capture_done("capture_stats");
        check_counts("capture_stats", `IMG_PIXELS);
    endtask

    task automatic test_skip_frames();
        start_capture(2'd2);
        fill_random_frame(4'h1);
        send_frame(-1);
        fill_random_frame(4'h2);
        send_frame(-1);
        check_value("skip_frames done before third frame", 0, 32'(cap_done_seen));
        fill_random_frame(4'h3);
        exp_px = frame_px;
        send_frame(-1);
        wait_capture_done("skip_frames");
        check_counts("skip_frames", `IMG_PIXELS);
        run_readout("skip_frames", 1'b0);
    endtask

    task automatic test_readout_stream();
        run_readout("readout_stream", 1'b0);
    endtask

    task automatic test_backpressure();
        run_readout("backpressure", 1'b1);
    endtask

    task automatic test_recapture();
        start_capture(2'd0);
        fill_stats_frame();
        send_frame(4);
        check_value("recapture done on cut frame", 0, 32'(cap_done_seen));
        check_value("recapture pixel count cleared", 0, 32'(capture_pixel_count));
        check_value("recapture highlights cleared", 0, 32'(capture_highlight_count));
        check_value("recapture shadows cleared", 0, 32'(capture_shadow_count));
        fill_random_frame(4'h0);
        exp_px = frame_px;
        send_frame(-1);
        wait_capture_done("recapture");
        check_counts("recapture", `IMG_PIXELS);
        run_readout("recapture", 1'b0);
    endtask

    initial begin
        arst_n          = 1'b0;
        cmd_capture     = 1'b0;
        cmd_readout     = 1'b0;
        cmd_skip_count  = '0;
        cmd_header      = '0;
        img_d           = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        readout_trigger = 1'b0;
        cap_done_seen   = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        step_clock();

        test_capture_stats();
        test_skip_frames();
        test_readout_stream();
        test_backpressure();
        test_recapture();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- img_ctrl.f
+incdir+include
src/pixel_pkg.sv
src/readout_pkg.sv
src/frame_bus_if.sv
src/pixel_capture.sv
src/frame_store.sv
src/fletcher_checksum.sv
src/readout_ctrl.sv
src/img_ctrl.sv
testbench/img_ctrl_properties.sv
testbench/img_ctrl_tb.sv

//--- Makefile
TOP = img_ctrl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f img_ctrl.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
